/* exu_macros.svh */
// Execute stage widths and sizes shared by packages, interface and RTL
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// --------------------
// Datapath widths
// --------------------

// Data and PC width
`define EXU_XLEN        64
// Width of the W-suffix operations
`define EXU_WORD_W      32

// --------------------
// Field widths
// --------------------

`define EXU_REG_IDX_W   5
`define EXU_CSR_IDX_W   12
// One decoded function word
`define EXU_FUNC_W      4
// RV64 shift amount
`define EXU_SHAMT_W     6

// Sequential fetch step in bytes
`define EXU_INST_BYTES  4

`endif

/* rv_isa_pkg.sv */
// RISC-V operation classes, function encodings and the shared function word
`include "exu_macros.svh"

package rv_isa_pkg;

  // --------------------
  // Operation class
  // --------------------
  typedef enum logic [1:0] {
    CLS_INT    = 2'd0,
    CLS_BRANCH = 2'd1,
    CLS_JUMP   = 2'd2,
    CLS_CSR    = 2'd3
  } op_class_e;

  // Integer ALU functions
  typedef enum logic [`EXU_FUNC_W-1:0] {
    FN_ADD   = 4'h0,
    FN_SUB   = 4'h1,
    FN_SLT   = 4'h2,
    FN_SLTU  = 4'h3,
    FN_AND   = 4'h4,
    FN_OR    = 4'h5,
    FN_XOR   = 4'h6,
    FN_SLL   = 4'h7,
    FN_SRL   = 4'h8,
    FN_SRA   = 4'h9,
    FN_LUI   = 4'ha,
    FN_AUIPC = 4'hb
  } alu_func_e;

  // Branch conditions, jumps share the same field
  typedef enum logic [`EXU_FUNC_W-1:0] {
    BR_EQ   = 4'h1,
    BR_NE   = 4'h2,
    BR_LT   = 4'h3,
    BR_GE   = 4'h4,
    BR_LTU  = 4'h5,
    BR_GEU  = 4'h6,
    BR_JAL  = 4'h7,
    BR_JALR = 4'h8
  } br_cond_e;

  // CSR ops, the I forms take the zimm from imm
  typedef enum logic [`EXU_FUNC_W-1:0] {
    CSR_RW  = 4'h1,
    CSR_RS  = 4'h2,
    CSR_RC  = 4'h3,
    CSR_RWI = 4'h4,
    CSR_RSI = 4'h5,
    CSR_RCI = 4'h6
  } csr_op_e;

  // One function word, meaning picked by op class
  typedef union packed {
    alu_func_e alu;
    br_cond_e  br;
    csr_op_e   csr;
  } exu_func_u;

endpackage

/* exu_func_pkg.sv */
// Helper functions for word sign-extension and signed compare
`include "exu_macros.svh"

package exu_func_pkg;

  // --------------------
  // Word handling
  // --------------------

  // Replicate bit 31 into the upper half
  function automatic logic [`EXU_XLEN-1:0] sext_word(input logic [`EXU_WORD_W-1:0] w);
    return {{(`EXU_XLEN-`EXU_WORD_W){w[`EXU_WORD_W-1]}}, w};
  endfunction

  // --------------------
  // Compare
  // --------------------

  // Two's complement less-than
  function automatic logic lt_signed(input logic [`EXU_XLEN-1:0] a,
                                     input logic [`EXU_XLEN-1:0] b);
    return $signed(a) < $signed(b);
  endfunction

endpackage

/* exu_issue_if.sv */
// Captured operation bus from the issue controller to the execution units
`timescale 1ns/100ps
`include "exu_macros.svh"

interface exu_issue_if import rv_isa_pkg::*; ();

  // One-cycle issue strobe
  logic                       issue_vld;
  op_class_e                  cls;
  exu_func_u                  func;
  logic                       use_imm;
  logic                       word_op;
  // Operands and PCs
  logic [`EXU_XLEN-1:0]       rs1;
  logic [`EXU_XLEN-1:0]       rs2;
  logic [`EXU_XLEN-1:0]       imm;
  logic [`EXU_XLEN-1:0]       pc;
  logic [`EXU_XLEN-1:0]       npc;
  logic [`EXU_XLEN-1:0]       csr_rdata;
  // Destinations
  logic [`EXU_REG_IDX_W-1:0]  rd_idx;
  logic [`EXU_CSR_IDX_W-1:0]  csr_idx;

  modport ctrl (output issue_vld, cls, func, use_imm, word_op, rs1, rs2, imm, pc, npc,
                       csr_rdata, rd_idx, csr_idx);

  modport unit (input  issue_vld, cls, func, use_imm, word_op, rs1, rs2, imm, pc, npc,
                       csr_rdata, rd_idx, csr_idx);

endinterface

/* exu_issue_ctrl.sv */
// Four-phase req/ack front end that captures one operation and issues it
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_issue_ctrl import rv_isa_pkg::*; (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      req,
  output logic                      ack,
  input  logic [1:0]                op_class,
  input  logic [`EXU_FUNC_W-1:0]    op_func,
  input  logic                      use_imm,
  input  logic                      word_op,
  input  logic [`EXU_XLEN-1:0]      rs1_data,
  input  logic [`EXU_XLEN-1:0]      rs2_data,
  input  logic [`EXU_XLEN-1:0]      imm,
  input  logic [`EXU_XLEN-1:0]      pc,
  input  logic [`EXU_XLEN-1:0]      npc,
  input  logic [`EXU_XLEN-1:0]      csr_rdata,
  input  logic [`EXU_REG_IDX_W-1:0] rd_idx,
  input  logic [`EXU_CSR_IDX_W-1:0] csr_idx,
  exu_issue_if.ctrl                 issue
);

  // Handshake states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ISSUED = 2'd1;
  localparam logic [1:0] ST_ACKED  = 2'd2;

  logic [1:0] state;
  logic       start;

  // New op only from idle, ack is low there
  assign start = req && (state == ST_IDLE);

  // --------------------
  // State
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:   if (start) state <= ST_ISSUED;
        // Units register results on this edge
        ST_ISSUED: state <= ST_ACKED;
        // Hold ack until the requester lets go
        ST_ACKED:  if (!req) state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // Strobe and ack decoded from state
  assign issue.issue_vld = (state == ST_ISSUED);
  assign ack             = (state == ST_ACKED);

  // --------------------
  // Operand capture
  // --------------------
  always_ff @(posedge clk) begin
    if (start) begin
      issue.cls       <= op_class_e'(op_class);
      issue.func      <= op_func;
      issue.use_imm   <= use_imm;
      issue.word_op   <= word_op;
      issue.rs1       <= rs1_data;
      issue.rs2       <= rs2_data;
      issue.imm       <= imm;
      issue.pc        <= pc;
      issue.npc       <= npc;
      issue.csr_rdata <= csr_rdata;
      issue.rd_idx    <= rd_idx;
      issue.csr_idx   <= csr_idx;
    end
  end

  // Ack only answers a pending request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    $rose(ack) |-> req);

  // Single-cycle issue per handshake
  a_issue_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
    issue.issue_vld |=> !issue.issue_vld);

endmodule

/* exu_int_unit.sv */
// Integer ALU with adder, compare, logic, shifter and GPR write-back register
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_int_unit import rv_isa_pkg::*, exu_func_pkg::*; (
  input  logic                      clk,
  input  logic                      rstn,
  exu_issue_if.unit                 issue,
  output logic                      gpr_wen,
  output logic [`EXU_XLEN-1:0]      gpr_wdata,
  output logic [`EXU_REG_IDX_W-1:0] gpr_idx
);

  localparam logic [`EXU_XLEN-1:0] INST_STEP = `EXU_XLEN'(`EXU_INST_BYTES);

  logic [`EXU_XLEN-1:0]    op2;
  logic [`EXU_SHAMT_W-1:0] shamt;
  logic [`EXU_XLEN-1:0]    alu_raw;
  logic [`EXU_XLEN-1:0]    alu_res;
  logic [`EXU_XLEN-1:0]    wb_data;
  logic                    wb_en;

  // Register or immediate second operand
  assign op2 = issue.use_imm ? issue.imm : issue.rs2;

  // W ops shift by 0..31 only
  assign shamt = issue.word_op ? {1'b0, op2[`EXU_SHAMT_W-2:0]} : op2[`EXU_SHAMT_W-1:0];

  // --------------------
  // ALU result
  // --------------------
  always_comb begin
    case (issue.func.alu)
      FN_ADD:   alu_raw = issue.rs1 + op2;
      FN_SUB:   alu_raw = issue.rs1 - op2;
      FN_SLT:   alu_raw = {{(`EXU_XLEN-1){1'b0}}, lt_signed(issue.rs1, op2)};
      FN_SLTU:  alu_raw = {{(`EXU_XLEN-1){1'b0}}, (issue.rs1 < op2)};
      FN_AND:   alu_raw = issue.rs1 & op2;
      FN_OR:    alu_raw = issue.rs1 | op2;
      FN_XOR:   alu_raw = issue.rs1 ^ op2;
      FN_SLL:   alu_raw = issue.rs1 << shamt;
      // W right shifts see only the low word
      FN_SRL: begin
        if (issue.word_op)
          alu_raw = {{(`EXU_XLEN-`EXU_WORD_W){1'b0}}, issue.rs1[`EXU_WORD_W-1:0]} >> shamt;
        else
          alu_raw = issue.rs1 >> shamt;
      end
      FN_SRA: begin
        if (issue.word_op)
          alu_raw = $signed(sext_word(issue.rs1[`EXU_WORD_W-1:0])) >>> shamt;
        else
          alu_raw = $signed(issue.rs1) >>> shamt;
      end
      FN_LUI:   alu_raw = issue.imm;
      FN_AUIPC: alu_raw = issue.pc + issue.imm;
      default:  alu_raw = '0;
    endcase
  end

  // W variants return a sign-extended word
  assign alu_res = issue.word_op ? sext_word(alu_raw[`EXU_WORD_W-1:0]) : alu_raw;

  // Write-back source by class, branches write nothing
  always_comb begin
    case (issue.cls)
      CLS_JUMP: wb_data = issue.pc + INST_STEP;
      CLS_CSR:  wb_data = issue.csr_rdata;
      default:  wb_data = alu_res;
    endcase
  end

  assign wb_en = issue.issue_vld && (issue.cls != CLS_BRANCH);

  // --------------------
  // Write-back register
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      gpr_wen <= 1'b0;
    else
      gpr_wen <= wb_en;
  end

  // Value held until next write
  always_ff @(posedge clk) begin
    if (wb_en) begin
      gpr_wdata <= wb_data;
      gpr_idx   <= issue.rd_idx;
    end
  end

  // Write pulse follows the issue strobe
  a_wen_after_issue: assert property (@(posedge clk) disable iff (!rstn)
    gpr_wen |-> $past(issue.issue_vld));

endmodule

/* exu_branch_unit.sv */
// Branch decision, jump target and fetch redirect against the predicted PC
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_branch_unit import rv_isa_pkg::*, exu_func_pkg::*; (
  input  logic                 clk,
  input  logic                 rstn,
  exu_issue_if.unit            issue,
  output logic                 redirect_vld,
  output logic [`EXU_XLEN-1:0] redirect_pc
);

  logic                 is_ctl;
  logic                 cond;
  logic                 taken;
  logic [`EXU_XLEN-1:0] target;
  logic [`EXU_XLEN-1:0] next_pc;

  assign is_ctl = (issue.cls == CLS_BRANCH) || (issue.cls == CLS_JUMP);

  // --------------------
  // Condition
  // --------------------
  always_comb begin
    case (issue.func.br)
      BR_EQ:   cond = (issue.rs1 == issue.rs2);
      BR_NE:   cond = (issue.rs1 != issue.rs2);
      BR_LT:   cond = lt_signed(issue.rs1, issue.rs2);
      BR_GE:   cond = !lt_signed(issue.rs1, issue.rs2);
      BR_LTU:  cond = (issue.rs1 < issue.rs2);
      BR_GEU:  cond = (issue.rs1 >= issue.rs2);
      default: cond = 1'b0;
    endcase
  end

  // Jumps always taken
  assign taken = (issue.cls == CLS_JUMP) || cond;

  // JALR is register based, the rest PC relative
  assign target  = (issue.func.br == BR_JALR) ? issue.rs1 + issue.imm : issue.pc + issue.imm;
  assign next_pc = taken ? target : issue.pc + `EXU_XLEN'(`EXU_INST_BYTES);

  // --------------------
  // Redirect register
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      redirect_vld <= 1'b0;
    else
      // Only on a mispredicted next PC
      redirect_vld <= issue.issue_vld && is_ctl && (next_pc != issue.npc);
  end

  always_ff @(posedge clk) begin
    if (issue.issue_vld && is_ctl)
      redirect_pc <= next_pc;
  end

  // Redirect only for branch and jump ops
  a_redirect_ctl_only: assert property (@(posedge clk) disable iff (!rstn)
    redirect_vld |-> ($past(issue.cls) inside {CLS_BRANCH, CLS_JUMP}));

endmodule

/* exu_csr_unit.sv */
// CSR new-value generation and CSR write register
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_csr_unit import rv_isa_pkg::*; (
  input  logic                      clk,
  input  logic                      rstn,
  exu_issue_if.unit                 issue,
  output logic                      csr_wen,
  output logic [`EXU_XLEN-1:0]      csr_wdata,
  output logic [`EXU_CSR_IDX_W-1:0] csr_widx
);

  logic                 csr_go;
  logic [`EXU_XLEN-1:0] src;
  logic [`EXU_XLEN-1:0] new_val;

  assign csr_go = issue.issue_vld && (issue.cls == CLS_CSR);

  // I forms take zimm from imm
  assign src = (issue.func.csr inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? issue.imm : issue.rs1;

  // Write, set or clear bits
  always_comb begin
    case (issue.func.csr)
      CSR_RW, CSR_RWI: new_val = src;
      CSR_RS, CSR_RSI: new_val = issue.csr_rdata | src;
      CSR_RC, CSR_RCI: new_val = issue.csr_rdata & ~src;
      default:         new_val = issue.csr_rdata;
    endcase
  end

  // --------------------
  // CSR write register
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      csr_wen <= 1'b0;
    else
      csr_wen <= csr_go;
  end

  always_ff @(posedge clk) begin
    if (csr_go) begin
      csr_wdata <= new_val;
      csr_widx  <= issue.csr_idx;
    end
  end

endmodule

/* exu_alu_top.sv */
// Integer execute stage top, handshake front end and three execution units
`timescale 1ns/100ps
`include "exu_macros.svh"

module exu_alu_top (
  input  logic                      clk,
  input  logic                      rstn,
  // Handshake
  input  logic                      req,
  output logic                      ack,
  // Operation fields, stable while req is high
  input  logic [1:0]                op_class,
  input  logic [`EXU_FUNC_W-1:0]    op_func,
  input  logic                      use_imm,
  input  logic                      word_op,
  input  logic [`EXU_XLEN-1:0]      rs1_data,
  input  logic [`EXU_XLEN-1:0]      rs2_data,
  input  logic [`EXU_XLEN-1:0]      imm,
  input  logic [`EXU_XLEN-1:0]      pc,
  input  logic [`EXU_XLEN-1:0]      npc,
  input  logic [`EXU_XLEN-1:0]      csr_rdata,
  input  logic [`EXU_REG_IDX_W-1:0] rd_idx,
  input  logic [`EXU_CSR_IDX_W-1:0] csr_idx,
  // GPR write-back
  output logic                      gpr_wen,
  output logic [`EXU_XLEN-1:0]      gpr_wdata,
  output logic [`EXU_REG_IDX_W-1:0] gpr_idx,
  // CSR write
  output logic                      csr_wen,
  output logic [`EXU_XLEN-1:0]      csr_wdata,
  output logic [`EXU_CSR_IDX_W-1:0] csr_widx,
  // Fetch redirect
  output logic                      redirect_vld,
  output logic [`EXU_XLEN-1:0]      redirect_pc
);

  exu_issue_if u_issue_if ();

  // --------------------
  // Front end
  // --------------------
  exu_issue_ctrl u_issue_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .req       (req),
    .ack       (ack),
    .op_class  (op_class),
    .op_func   (op_func),
    .use_imm   (use_imm),
    .word_op   (word_op),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .pc        (pc),
    .npc       (npc),
    .csr_rdata (csr_rdata),
    .rd_idx    (rd_idx),
    .csr_idx   (csr_idx),
    .issue     (u_issue_if.ctrl)
  );

  // --------------------
  // Units
  // --------------------
  exu_int_unit u_int_unit (
    .clk       (clk),
    .rstn      (rstn),
    .issue     (u_issue_if.unit),
    .gpr_wen   (gpr_wen),
    .gpr_wdata (gpr_wdata),
    .gpr_idx   (gpr_idx)
  );

  exu_branch_unit u_branch_unit (
    .clk          (clk),
    .rstn         (rstn),
    .issue        (u_issue_if.unit),
    .redirect_vld (redirect_vld),
    .redirect_pc  (redirect_pc)
  );

  exu_csr_unit u_csr_unit (
    .clk       (clk),
    .rstn      (rstn),
    .issue     (u_issue_if.unit),
    .csr_wen   (csr_wen),
    .csr_wdata (csr_wdata),
    .csr_widx  (csr_widx)
  );

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source for the execute stage
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held low for 16 cycles
  initial begin
    rstn = 1'b0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

/* tb_exu_alu.sv */
// Directed testbench for the integer execute stage over the req/ack handshake
`timescale 1ns/100ps
`include "exu_macros.svh"

module tb_exu_alu import rv_isa_pkg::*; ();

  localparam int TIMEOUT = 20;

  logic clk, rstn, req, ack, use_imm, word_op;
  logic [1:0]                op_class;
  logic [`EXU_FUNC_W-1:0]    op_func;
  logic [`EXU_XLEN-1:0]      rs1_data, rs2_data, imm, pc, npc, csr_rdata;
  logic [`EXU_REG_IDX_W-1:0] rd_idx, gpr_idx;
  logic [`EXU_CSR_IDX_W-1:0] csr_idx, csr_widx;
  logic                      gpr_wen, csr_wen, redirect_vld;
  logic [`EXU_XLEN-1:0]      gpr_wdata, csr_wdata, redirect_pc;

  int errors, tests_run, tests_failed, lat, extra;
  logic [15:0] lfsr;
  // Outputs seen in the first ack cycle
  logic                      s_gpr_wen, s_csr_wen, s_rd_vld;
  logic [`EXU_XLEN-1:0]      s_gpr_wdata, s_csr_wdata, s_rd_pc;
  logic [`EXU_REG_IDX_W-1:0] s_gpr_idx;
  logic [`EXU_CSR_IDX_W-1:0] s_csr_widx;

  tb_clk_gen u_clk_gen (.clk(clk), .rstn(rstn));

  exu_alu_top u_dut (
    .clk(clk), .rstn(rstn), .req(req), .ack(ack),
    .op_class(op_class), .op_func(op_func), .use_imm(use_imm), .word_op(word_op),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc), .npc(npc),
    .csr_rdata(csr_rdata), .rd_idx(rd_idx), .csr_idx(csr_idx),
    .gpr_wen(gpr_wen), .gpr_wdata(gpr_wdata), .gpr_idx(gpr_idx),
    .csr_wen(csr_wen), .csr_wdata(csr_wdata), .csr_widx(csr_widx),
    .redirect_vld(redirect_vld), .redirect_pc(redirect_pc)
  );

  // --------------------
  // Stimulus helpers
  // --------------------

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Full four-phase exchange for one operation
  task automatic run_op(input logic [1:0] cls, input logic [3:0] fn, input logic ui,
      input logic wo, input logic [63:0] a, input logic [63:0] b, input logic [63:0] im,
      input logic [63:0] p, input logic [63:0] np, input logic [63:0] cr,
      input logic [4:0] rd, input logic [11:0] ci, input int hold);
    int n;
    @(posedge clk);
    op_class <= cls;
    op_func <= fn;
    use_imm <= ui;
    word_op <= wo;
    rs1_data <= a;
    rs2_data <= b;
    imm <= im;
    pc <= p;
    npc <= np;
    csr_rdata <= cr;
    rd_idx <= rd;
    csr_idx <= ci;
    req <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < TIMEOUT);
    if (!ack) begin
      $display("Timed out waiting for ack to rise");
      errors++;
    end
    // Falling edges counted from the drive edge, minus the one before req is sampled
    lat = n - 1;
    if (ack && lat != 2) begin
      $display("[FAIL] %0t ns: ack came %0d edges after req, expected 2", $time, lat);
      errors++;
    end
    s_gpr_wen = gpr_wen;
    s_gpr_wdata = gpr_wdata;
    s_gpr_idx = gpr_idx;
    s_csr_wen = csr_wen;
    s_csr_wdata = csr_wdata;
    s_csr_widx = csr_widx;
    s_rd_vld = redirect_vld;
    s_rd_pc = redirect_pc;
    // Back-pressure, ack held and no second pulse
    extra = 0;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!ack) begin
        $display("[FAIL] %0t ns: ack dropped while req was still high", $time);
        errors++;
      end
      if (gpr_wen || csr_wen || redirect_vld)
        extra++;
    end
    if (extra != 0) begin
      $display("[FAIL] %0t ns: %0d extra pulses while req was held", $time, extra);
      errors++;
    end
    @(posedge clk);
    req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ack && n < TIMEOUT);
    if (ack) begin
      $display("Timed out waiting for ack to fall after req dropped");
      errors++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Integer result from the ISA rules, b already chosen as operand 2
  function automatic logic [63:0] exp_alu(input logic [3:0] fn, input logic [63:0] a,
      input logic [63:0] b, input logic wo, input logic [63:0] im, input logic [63:0] p);
    logic [31:0] w;
    logic [63:0] r;
    int sh;
    sh = wo ? int'(b[4:0]) : int'(b[5:0]);
    w = '0;
    case (fn)
      FN_ADD:   r = a + b;
      FN_SUB:   r = a - b;
      FN_SLT:   r = {63'd0, $signed(a) < $signed(b)};
      FN_SLTU:  r = {63'd0, a < b};
      FN_AND:   r = a & b;
      FN_OR:    r = a | b;
      FN_XOR:   r = a ^ b;
      FN_SLL:   r = a << sh;
      FN_SRL: begin
        w = a[31:0] >> sh;
        r = wo ? {32'd0, w} : a >> sh;
      end
      FN_SRA: begin
        if (wo) begin
          w = $signed(a[31:0]) >>> sh;
          r = {32'd0, w};
        end else begin
          r = $signed(a) >>> sh;
        end
      end
      FN_LUI:   r = im;
      FN_AUIPC: r = p + im;
      default:  r = '0;
    endcase
    if (wo)
      r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  // Integer write-back only, no CSR write or redirect
  task automatic check_int(input logic [63:0] exp, input logic [4:0] rd);
    expect_bit("gpr_wen", s_gpr_wen, 1'b1);
    expect_eq("gpr_wdata", s_gpr_wdata, exp);
    expect_eq("gpr_idx", 64'(s_gpr_idx), 64'(rd));
    expect_bit("csr_wen on int op", s_csr_wen, 1'b0);
    expect_bit("redirect_vld on int op", s_rd_vld, 1'b0);
  endtask

  task automatic finish_test(input string name, input int e0);
    tests_run++;
    if (errors != e0)
      tests_failed++;
    $display("%s: %0d errors", name, errors - e0);
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic test_reset_handshake();
    int n;
    int e0;
    e0 = errors;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rstn && n < 40);
    if (!rstn) begin
      $display("Timed out waiting for reset release");
      errors++;
    end
    expect_bit("ack after reset", ack, 1'b0);
    expect_bit("issue_vld after reset", u_dut.u_issue_if.issue_vld, 1'b0);
    expect_bit("gpr_wen after reset", gpr_wen, 1'b0);
    expect_bit("csr_wen after reset", csr_wen, 1'b0);
    expect_bit("redirect_vld after reset", redirect_vld, 1'b0);
    // Hold req 5 cycles past ack
    run_op(CLS_INT, FN_ADD, 1'b0, 1'b0, 64'd5, 64'd7, 64'd0, 64'd0, 64'd0, 64'd0,
           5'd3, 12'd0, 5);
    check_int(64'd12, 5'd3);
    finish_test("reset_handshake", e0);
  endtask

  task automatic test_arith();
    logic [3:0] fns [4];
    logic [63:0] a, b, im, t;
    logic [4:0] rd;
    int e0;
    e0 = errors;
    fns = '{FN_ADD, FN_SUB, FN_SLT, FN_SLTU};
    for (int i = 0; i < 3; i++) begin
      for (int f = 0; f < 4; f++) begin
        for (int u = 0; u < 2; u++) begin
          draw_bits(64, a);
          draw_bits(64, b);
          draw_bits(12, t);
          im = {{52{t[11]}}, t[11:0]};
          draw_bits(5, t);
          rd = t[4:0];
          run_op(CLS_INT, fns[f], u[0], 1'b0, a, b, im, 64'd0, 64'd0, 64'd0, rd, 12'd0, 0);
          check_int(exp_alu(fns[f], a, u[0] ? im : b, 1'b0, im, 64'd0), rd);
        end
      end
    end
    finish_test("arith", e0);
  endtask

  task automatic test_logic_shift();
    logic [3:0] fns [6];
    logic [3:0] wfns [5];
    logic [63:0] a, b, im, p, t;
    logic [4:0] rd;
    int e0;
    e0 = errors;
    fns = '{FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SRA};
    wfns = '{FN_ADD, FN_SUB, FN_SLL, FN_SRL, FN_SRA};
    for (int i = 0; i < 2; i++) begin
      for (int f = 0; f < 11; f++) begin
        draw_bits(64, a);
        draw_bits(64, b);
        draw_bits(64, im);
        draw_bits(5, t);
        rd = t[4:0];
        if (f < 6) begin
          run_op(CLS_INT, fns[f], i[0], 1'b0, a, b, im, 64'd0, 64'd0, 64'd0, rd, 12'd0, 0);
          check_int(exp_alu(fns[f], a, i[0] ? im : b, 1'b0, im, 64'd0), rd);
        end else begin
          // Word variants, result sign-extended from bit 31
          run_op(CLS_INT, wfns[f-6], i[0], 1'b1, a, b, im, 64'd0, 64'd0, 64'd0, rd, 12'd0, 0);
          check_int(exp_alu(wfns[f-6], a, i[0] ? im : b, 1'b1, im, 64'd0), rd);
        end
      end
    end
    // Word add crossing into bit 31
    run_op(CLS_INT, FN_ADD, 1'b0, 1'b1, 64'h0000_0000_7FFF_FFFF, 64'd1, 64'd0, 64'd0, 64'd0,
           64'd0, 5'd9, 12'd0, 0);
    check_int(64'hFFFF_FFFF_8000_0000, 5'd9);
    draw_bits(32, t);
    im = {{32{t[31]}}, t[31:12], 12'd0};
    draw_bits(64, p);
    run_op(CLS_INT, FN_LUI, 1'b1, 1'b0, 64'd0, 64'd0, im, p, 64'd0, 64'd0, 5'd4, 12'd0, 0);
    check_int(im, 5'd4);
    run_op(CLS_INT, FN_AUIPC, 1'b1, 1'b0, 64'd0, 64'd0, im, p, 64'd0, 64'd0, 5'd6, 12'd0, 0);
    check_int(p + im, 5'd6);
    finish_test("logic_shift", e0);
  endtask

  task automatic test_branches();
    logic [3:0] conds [6];
    logic [63:0] x, a, b, p, im, t, tgt, nxt, np;
    logic taken;
    int e0;
    e0 = errors;
    conds = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
    for (int c = 0; c < 6; c++) begin
      // Rows: equal, less, greater
      for (int r = 0; r < 3; r++) begin
        draw_bits(64, x);
        draw_bits(64, t);
        p = {t[63:2], 2'b00};
        draw_bits(13, t);
        im = {{51{t[12]}}, t[12:1], 1'b0};
        a = (r == 2) ? x + 64'd1 : x;
        b = (r == 1) ? x + 64'd1 : x;
        case (conds[c])
          BR_EQ:   taken = (a == b);
          BR_NE:   taken = (a != b);
          BR_LT:   taken = ($signed(a) < $signed(b));
          BR_GE:   taken = ($signed(a) >= $signed(b));
          BR_LTU:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        tgt = p + im;
        nxt = taken ? tgt : p + 64'd4;
        // Alternate predictions so both redirect outcomes occur
        np = ((c + r) % 2 == 0) ? p + 64'd4 : tgt;
        run_op(CLS_BRANCH, conds[c], 1'b0, 1'b0, a, b, im, p, np, 64'd0, 5'd1, 12'd0, 0);
        expect_eq("redirect_pc", s_rd_pc, nxt);
        expect_bit("redirect_vld", s_rd_vld, nxt != np);
        expect_bit("gpr_wen on branch", s_gpr_wen, 1'b0);
      end
    end
    finish_test("branches", e0);
  endtask

  task automatic test_jumps();
    logic [63:0] a, p, im, t, tgt, np;
    logic [4:0] rd;
    int e0;
    e0 = errors;
    for (int j = 0; j < 2; j++) begin
      // k = 1 predicts the target, no redirect expected
      for (int k = 0; k < 2; k++) begin
        draw_bits(64, t);
        p = {t[63:2], 2'b00};
        draw_bits(64, t);
        a = {t[63:2], 2'b00};
        draw_bits(13, t);
        im = {{51{t[12]}}, t[12:1], 1'b0};
        draw_bits(5, t);
        rd = t[4:0];
        tgt = (j == 0) ? p + im : a + im;
        np = (k == 1) ? tgt : p + 64'd4;
        run_op(CLS_JUMP, (j == 0) ? BR_JAL : BR_JALR, 1'b1, 1'b0, a, 64'd0, im, p, np,
               64'd0, rd, 12'd0, 0);
        expect_bit("gpr_wen on jump", s_gpr_wen, 1'b1);
        expect_eq("link value", s_gpr_wdata, p + 64'd4);
        expect_eq("link gpr_idx", 64'(s_gpr_idx), 64'(rd));
        expect_eq("jump redirect_pc", s_rd_pc, tgt);
        expect_bit("jump redirect_vld", s_rd_vld, tgt != np);
      end
    end
    finish_test("jumps", e0);
  endtask

  task automatic test_csr();
    logic [3:0] ops [6];
    logic [63:0] a, cr, zimm, src, exp, t;
    logic [4:0] rd;
    logic [11:0] ci;
    int e0;
    e0 = errors;
    ops = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    for (int o = 0; o < 6; o++) begin
      draw_bits(64, a);
      draw_bits(64, cr);
      draw_bits(5, t);
      zimm = {59'd0, t[4:0]};
      draw_bits(12, t);
      ci = t[11:0];
      draw_bits(5, t);
      rd = t[4:0];
      src = (o >= 3) ? zimm : a;
      case (o % 3)
        0:       exp = src;
        1:       exp = cr | src;
        default: exp = cr & ~src;
      endcase
      run_op(CLS_CSR, ops[o], 1'b0, 1'b0, a, 64'd0, zimm, 64'd0, 64'd0, cr, rd, ci, 0);
      expect_bit("csr_wen", s_csr_wen, 1'b1);
      expect_eq("csr_wdata", s_csr_wdata, exp);
      expect_eq("csr_widx", 64'(s_csr_widx), 64'(ci));
      // Old CSR value goes to rd
      expect_bit("gpr_wen on csr", s_gpr_wen, 1'b1);
      expect_eq("csr old value to rd", s_gpr_wdata, cr);
      expect_eq("csr gpr_idx", 64'(s_gpr_idx), 64'(rd));
      expect_bit("redirect_vld on csr", s_rd_vld, 1'b0);
    end
    finish_test("csr", e0);
  endtask

  // --------------------
  // Sequence
  // --------------------
  initial begin
    req = 1'b0;
    op_class = '0;
    op_func = '0;
    use_imm = 1'b0;
    word_op = 1'b0;
    rs1_data = '0;
    rs2_data = '0;
    imm = '0;
    pc = '0;
    npc = '0;
    csr_rdata = '0;
    rd_idx = '0;
    csr_idx = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr = 16'd57796;
    test_reset_handshake();
    test_arith();
    test_logic_shift();
    test_branches();
    test_jumps();
    test_csr();
    $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
rv_isa_pkg.sv
exu_func_pkg.sv
exu_issue_if.sv
exu_issue_ctrl.sv
exu_int_unit.sv
exu_branch_unit.sv
exu_csr_unit.sv
exu_alu_top.sv
tb_clk_gen.sv
tb_exu_alu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f build.f --top-module tb_exu_alu -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict from the log
if grep -q "^test passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
